// ==== rtl/feature_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module feature_core import feature_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  logic      filter_on,
    input  pixel_t    threshold,
    input  logic      img_we,
    input  row_addr_t img_addr,
    input  row_t      img_din,
    input  kp_addr_t  kp_addr,
    output logic      done,
    output kp_entry_t kp_dout,
    output kp_count_t kp_count
);

    core_state_t state;
    core_state_t next_state;

    logic      blur_go;                     // one pulse on entry to blur
    logic      det_go;                      // one pulse on entry to detect
    logic      blur_finished;
    logic      det_finished;

    logic      orig_we;
    row_addr_t orig_raddr;
    row_t      orig_rdata;
    row_t      blur_rdata;

    row_addr_t blur_img_raddr;              // blur engine read address
    logic      blur_we;
    row_addr_t blur_waddr;
    row_t      blur_wdata;
    row_addr_t det_raddr;                   // detector read address, both mems

    // host writes only while idle, runs are protected
    assign orig_we = img_we && (state == st_idle);

    always_comb begin
        case (state)
            st_idle:   orig_raddr = img_addr;
            st_blur:   orig_raddr = blur_img_raddr;
            st_detect: orig_raddr = det_raddr;
            default:   orig_raddr = '0;
        endcase
    end

    frame_mem orig_mem (
        .clk   (clk),
        .we    (orig_we),
        .waddr (img_addr),
        .wdata (img_din),
        .raddr (orig_raddr),
        .rdata (orig_rdata)
    );

    frame_mem blur_mem (
        .clk   (clk),
        .we    (blur_we),                   // blur engine only
        .waddr (blur_waddr),
        .wdata (blur_wdata),
        .raddr (det_raddr),                 // detector only
        .rdata (blur_rdata)
    );

    gaussian_blur blur_eng (
        .clk        (clk),
        .rst_n      (rst_n),
        .go         (blur_go),
        .img_row    (orig_rdata),
        .img_raddr  (blur_img_raddr),
        .blur_we    (blur_we),
        .blur_waddr (blur_waddr),
        .blur_wdata (blur_wdata),
        .finished   (blur_finished)
    );

    keypoint_detect det_eng (
        .clk       (clk),
        .rst_n     (rst_n),
        .go        (det_go),
        .filter_on (filter_on),
        .threshold (threshold),
        .orig_row  (orig_rdata),
        .blur_row  (blur_rdata),
        .kp_addr   (kp_addr),
        .row_raddr (det_raddr),
        .kp_dout   (kp_dout),
        .kp_count  (kp_count),
        .finished  (det_finished)
    );

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (start && !done) begin
                    next_state = st_blur;   // new request
                end
            end
            st_blur: begin
                if (blur_finished) begin
                    next_state = st_detect;
                end
            end
            st_detect: begin
                if (det_finished) begin
                    next_state = st_finish;
                end
            end
            default: begin
                if (!start) begin
                    next_state = st_idle;   // req dropped, release ack
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= st_idle;
            blur_go <= 1'b0;
            det_go  <= 1'b0;
            done    <= 1'b0;
        end else begin
            state   <= next_state;
            blur_go <= (state == st_idle) && (next_state == st_blur);
            det_go  <= (state == st_blur) && (next_state == st_detect);
            if (det_finished) begin
                done <= 1'b1;               // ack, held while start high
            end else if ((state == st_finish) && !start) begin
                done <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/feature_pkg.sv ====
`default_nettype none

package feature_pkg;

    // image geometry
    localparam int img_w    = 16;    // pixels per row
    localparam int img_h    = 16;    // rows per frame
    localparam int pix_w    = 8;     // bits per pixel

    // keypoint list
    localparam int kp_depth = 64;    // max stored keypoints

    // pixel, also used for the threshold
    typedef logic [pix_w-1:0] pixel_t;

    // full row, pixel 0 in the low bits
    typedef logic [img_w*pix_w-1:0] row_t;

    typedef logic [3:0] row_addr_t;  // row index 0..15
    typedef logic [3:0] col_t;       // column index 0..15

    // {row, col} packed entry
    typedef logic [7:0] kp_entry_t;

    typedef logic [5:0] kp_addr_t;   // list index 0..63
    typedef logic [6:0] kp_count_t;  // count 0..64, needs the extra bit

    // pass control
    typedef enum logic [1:0] {
        st_idle,                     // host owns orig memory
        st_blur,                     // gaussian pass running
        st_detect,                   // keypoint scan running
        st_finish                    // done high, wait for start low
    } core_state_t;

endpackage

`default_nettype wire

// ==== rtl/frame_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_mem import feature_pkg::*; (
    input  logic      clk,
    input  logic      we,
    input  row_addr_t waddr,
    input  row_t      wdata,
    input  row_addr_t raddr,
    output row_t      rdata
);

    row_t mem [img_h];                      // one row per address

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;            // full row write
        end
        rdata <= mem[raddr];                // registered read, 1 cycle latency
    end

endmodule

`default_nettype wire

// ==== rtl/gaussian_blur.sv ====
`timescale 1ns/1ps
`default_nettype none

module gaussian_blur import feature_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      go,
    input  row_t      img_row,
    output row_addr_t img_raddr,
    output logic      blur_we,
    output row_addr_t blur_waddr,
    output row_t      blur_wdata,
    output logic      finished
);

    logic        active;                    // read sequencer running
    logic [4:0]  rd_cnt;                    // 0..15 rows, 16 = zero step
    logic        rd_vld;                    // memory data valid this cycle
    logic        rd_zero;                   // this step shifts a zero row
    logic [4:0]  rd_idx;                    // step index of the data in flight
    logic        wr_vld;                    // window centre holds a real row
    row_addr_t   wr_row;                    // index of that centre row
    row_t        row_top;
    row_t        row_mid;
    row_t        row_bot;
    logic [9:0]  vsum [img_w+2];            // column sums, padded both sides
    logic [11:0] hsum [img_w];              // full 3x3 weighted sum

    row_window win (
        .clk     (clk),
        .rst_n   (rst_n),
        .shift   (rd_vld),
        .clear   (go),
        .row_in  (img_row),
        .zero_in (rd_zero),
        .row_top (row_top),
        .row_mid (row_mid),
        .row_bot (row_bot)
    );

    assign img_raddr  = rd_cnt[3:0];        // step 16 reads row 0, data ignored
    assign blur_we    = wr_vld;
    assign blur_waddr = wr_row;

    // kernel 1-2-1 vertical then 1-2-1 horizontal, total weight 16
    always_comb begin
        vsum[0]       = '0;                 // column -1
        vsum[img_w+1] = '0;                 // column 16
        for (int c = 0; c < img_w; c++) begin
            vsum[c+1] = {2'b00, row_top[c*pix_w +: pix_w]}
                      + {1'b0, row_mid[c*pix_w +: pix_w], 1'b0}
                      + {2'b00, row_bot[c*pix_w +: pix_w]};
        end
        for (int c = 0; c < img_w; c++) begin
            hsum[c] = {2'b00, vsum[c]}
                    + {1'b0, vsum[c+1], 1'b0}
                    + {2'b00, vsum[c+2]};   // max 4080, fits 12 bits
            blur_wdata[c*pix_w +: pix_w] = hsum[c][11:4];  // divide by 16, truncate
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active   <= 1'b0;
            rd_cnt   <= '0;
            rd_vld   <= 1'b0;
            rd_zero  <= 1'b0;
            rd_idx   <= '0;
            wr_vld   <= 1'b0;
            wr_row   <= '0;
            finished <= 1'b0;
        end else begin
            rd_vld   <= active;
            rd_zero  <= active && (rd_cnt == 5'(img_h));
            rd_idx   <= rd_cnt;
            // first shift only fills the bottom slot, no output yet
            wr_vld   <= rd_vld && (rd_idx != '0);
            wr_row   <= row_addr_t'(rd_idx - 5'd1);   // centre lags one row
            finished <= wr_vld && (wr_row == row_addr_t'(img_h - 1));
            if (go) begin
                active <= 1'b1;
                rd_cnt <= '0;
            end else if (active) begin
                rd_cnt <= rd_cnt + 5'd1;
                if (rd_cnt == 5'(img_h)) begin
                    active <= 1'b0;         // zero step issued, stop
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/keypoint_detect.sv ====
`timescale 1ns/1ps
`default_nettype none

module keypoint_detect import feature_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      go,
    input  logic      filter_on,
    input  pixel_t    threshold,
    input  row_t      orig_row,
    input  row_t      blur_row,
    input  kp_addr_t  kp_addr,
    output row_addr_t row_raddr,
    output kp_entry_t kp_dout,
    output kp_count_t kp_count,
    output logic      finished
);

    logic      fetch_q;                     // row address presented
    logic      settle_q;                    // memory data valid, latch it
    logic      scan_q;                      // column checks running
    row_addr_t row;
    col_t      col;
    row_t      orig_q;                      // latched original row
    row_t      blur_q;                      // latched blurred row
    kp_entry_t kp_list [kp_depth];
    pixel_t    orig_pix;
    pixel_t    blur_pix;
    pixel_t    diff;
    logic      hit;
    logic      kp_we;

    assign row_raddr = row;                 // same row from both memories
    assign kp_dout   = kp_list[kp_addr];    // async readback

    always_comb begin
        orig_pix = orig_q[col*pix_w +: pix_w];
        blur_pix = blur_q[col*pix_w +: pix_w];
        if (orig_pix > blur_pix) begin
            diff = orig_pix - blur_pix;     // absolute difference
        end else begin
            diff = blur_pix - orig_pix;
        end
        if (filter_on) begin
            hit = scan_q && (diff > threshold);
        end else begin
            hit = scan_q && (diff != '0);
        end
    end

    assign kp_we = hit && (kp_count != kp_count_t'(kp_depth));  // drop once full

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_q  <= 1'b0;
            settle_q <= 1'b0;
            scan_q   <= 1'b0;
            row      <= '0;
            col      <= '0;
            kp_count <= '0;
            finished <= 1'b0;
        end else begin
            finished <= 1'b0;
            if (go) begin
                fetch_q  <= 1'b1;           // start at row 0
                settle_q <= 1'b0;
                scan_q   <= 1'b0;
                row      <= '0;
                col      <= '0;
                kp_count <= '0;             // fresh list
            end else begin
                if (fetch_q) begin
                    fetch_q  <= 1'b0;
                    settle_q <= 1'b1;
                end
                if (settle_q) begin
                    settle_q <= 1'b0;
                    scan_q   <= 1'b1;
                    col      <= '0;
                end
                if (scan_q) begin
                    col <= col + 4'd1;
                    if (col == col_t'(img_w - 1)) begin
                        scan_q <= 1'b0;
                        if (row == row_addr_t'(img_h - 1)) begin
                            finished <= 1'b1;   // last pixel checked
                        end else begin
                            row     <= row + 4'd1;
                            fetch_q <= 1'b1;    // next row pair
                        end
                    end
                end
                if (kp_we) begin
                    kp_count <= kp_count + 7'd1;  // saturates at kp_depth
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (settle_q) begin
            orig_q <= orig_row;
            blur_q <= blur_row;
        end
        if (kp_we) begin
            kp_list[kp_count[5:0]] <= {row, col};   // row high, col low
        end
    end

endmodule

`default_nettype wire

// ==== rtl/row_window.sv ====
`timescale 1ns/1ps
`default_nettype none

module row_window import feature_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic shift,
    input  logic clear,
    input  row_t row_in,
    input  logic zero_in,
    output row_t row_top,
    output row_t row_mid,
    output row_t row_bot
);

    // three-row stack, oldest row on top
    // a cleared stack supplies the zero row above the image
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_top <= '0;
            row_mid <= '0;
            row_bot <= '0;
        end else if (clear) begin
            row_top <= '0;                  // new pass, empty window
            row_mid <= '0;
            row_bot <= '0;
        end else if (shift) begin
            row_top <= row_mid;             // move up one
            row_mid <= row_bot;
            if (zero_in) begin
                row_bot <= '0;              // bottom border row
            end else begin
                row_bot <= row_in;          // fresh row from memory
            end
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the feature_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing -f verilog.f --top-module tb_feature_core \
    -Mdir "$build_dir" -o tb_feature_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/tb_feature_core" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" "$log"; then
    exit 1
fi
exit 0

// ==== test/tb_feature_model.svh ====
`ifndef TB_FEATURE_MODEL_SVH
`define TB_FEATURE_MODEL_SVH

// whole image in one vector, row 0 pixel 0 in the low bits
typedef logic [img_h*img_w*pix_w-1:0] frame_t;

function automatic pixel_t pixel_at(input frame_t f, input int r, input int c);
    if (r < 0 || r >= img_h || c < 0 || c >= img_w) begin
        return '0;                                  // outside the image
    end
    return f[(r*img_w + c)*pix_w +: pix_w];
endfunction

function automatic row_t frame_row(input frame_t f, input int r);
    return f[r*img_w*pix_w +: img_w*pix_w];
endfunction

// direct 3x3 sum, weights are the outer product of 1-2-1
function automatic pixel_t blurred_at(input frame_t f, input int r, input int c);
    int acc;
    int w;
    acc = 0;
    for (int dr = -1; dr <= 1; dr++) begin
        for (int dc = -1; dc <= 1; dc++) begin
            w = (dr == 0 ? 2 : 1) * (dc == 0 ? 2 : 1);
            acc += w * int'(pixel_at(f, r + dr, c + dc));
        end
    end
    return pixel_t'(acc / 16);                      // truncating divide
endfunction

function automatic logic is_keypoint(input frame_t f, input int r, input int c,
                                     input logic filt, input pixel_t thr);
    int diff;
    diff = int'(pixel_at(f, r, c)) - int'(blurred_at(f, r, c));
    if (diff < 0) begin
        diff = -diff;
    end
    if (filt) begin
        return diff > int'(thr);
    end
    return diff != 0;
endfunction

function automatic kp_count_t expected_count(input frame_t f, input logic filt,
                                             input pixel_t thr);
    int n;
    n = 0;
    for (int r = 0; r < img_h; r++) begin
        for (int c = 0; c < img_w; c++) begin
            if (is_keypoint(f, r, c, filt, thr) && n < kp_depth) begin
                n++;                                // list caps at kp_depth
            end
        end
    end
    return kp_count_t'(n);
endfunction

// idx-th keypoint in row-major order
function automatic kp_entry_t expected_entry(input frame_t f, input logic filt,
                                             input pixel_t thr, input int idx);
    int n;
    n = 0;
    for (int r = 0; r < img_h; r++) begin
        for (int c = 0; c < img_w; c++) begin
            if (is_keypoint(f, r, c, filt, thr)) begin
                if (n == idx) begin
                    return {row_addr_t'(r), col_t'(c)};
                end
                n++;
            end
        end
    end
    return '0;
endfunction

// galois form, taps x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
        return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
endfunction

`endif

// ==== test/tb_feature_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_feature_core import feature_pkg::*; ();

    `include "tb_feature_model.svh"

    localparam int num_tests   = 8;
    localparam int load_cycles = img_h;             // one row per cycle
    localparam int run_cycles  = 800;               // blur + detect + handshake plus margin
    localparam int read_cycles = kp_depth;
    localparam int cycle_limit = num_tests * (load_cycles + run_cycles + read_cycles);

    localparam int kind_flat    = 0;
    localparam int kind_single  = 1;
    localparam int kind_checker = 2;
    localparam int kind_random  = 3;
    localparam int kind_keep    = 4;                // previous image stays loaded

    // stimulus table with one column per array
    // a t_count of -1 leaves the count to the model
    string  t_name   [num_tests] = '{"flat_border", "single_bright", "checker_cap",
                                     "random_lo", "random_hi", "hold_start",
                                     "busy_write", "checker_thr"};
    int     t_kind   [num_tests] = '{kind_flat, kind_single, kind_checker, kind_random,
                                     kind_random, kind_flat, kind_keep, kind_checker};
    logic   t_filter [num_tests] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1};
    pixel_t t_thr    [num_tests] = '{8'd0, 8'd100, 8'd0, 8'd20, 8'd90, 8'd10, 8'd0, 8'd100};
    int     t_count  [num_tests] = '{60, 1, 64, -1, -1, 60, 60, 30};
    int     t_hold   [num_tests] = '{0, 0, 0, 0, 0, 6, 0, 0};
    logic   t_busy   [num_tests] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};

    logic      clk = 1'b0;
    logic      rst_n;
    logic      start;
    logic      filter_on;
    pixel_t    threshold;
    logic      img_we;
    row_addr_t img_addr;
    row_t      img_din;
    kp_addr_t  kp_addr;
    logic      done;
    kp_entry_t kp_dout;
    kp_count_t kp_count;

    frame_t      frame;                             // image held in orig memory
    logic [31:0] lfsr        = 32'hadfa;
    int          cycle_count = 0;
    int          checks      = 0;
    int          errors      = 0;

    feature_core uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .filter_on (filter_on),
        .threshold (threshold),
        .img_we    (img_we),
        .img_addr  (img_addr),
        .img_din   (img_din),
        .kp_addr   (kp_addr),
        .done      (done),
        .kp_dout   (kp_dout),
        .kp_count  (kp_count)
    );

    always #10 clk = ~clk;                          // 20 ns period

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_count);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic check_count(input string name, input kp_count_t exp, input kp_count_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: kp_count expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_entry(input string name, input int idx, input kp_entry_t exp,
                               input kp_entry_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: entry %0d expected %02h actual %02h",
                     name, idx, exp, act);
        end
    endtask

    task automatic report_problem(input string name, input string what);
        errors++;
        $display("ERROR %s: %s", name, what);
    endtask

    task automatic next_random_pixel(output pixel_t p);
        for (int b = 0; b < pix_w; b++) begin
            p[b] = lfsr[0];                         // one step per bit
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic build_image(input int kind);
        pixel_t p;
        for (int r = 0; r < img_h; r++) begin
            for (int c = 0; c < img_w; c++) begin
                case (kind)
                    kind_flat:    p = 8'd80;
                    kind_single:  p = (r == 7 && c == 9) ? 8'd200 : 8'd0;
                    kind_checker: p = ((r + c) % 2 == 0) ? 8'd200 : 8'd0;
                    default:      next_random_pixel(p);
                endcase
                frame[(r*img_w + c)*pix_w +: pix_w] = p;
            end
        end
    endtask

    task automatic load_image();
        for (int r = 0; r < img_h; r++) begin
            @(negedge clk);
            img_we   = 1'b1;
            img_addr = row_addr_t'(r);
            img_din  = frame_row(frame, r);
        end
        @(negedge clk);
        img_we = 1'b0;
    endtask

    // four-phase req/ack with optional req hold and busy writes
    task automatic run_core(input string name, input int hold, input logic busy);
        int n;
        n = 0;
        @(negedge clk);
        if (done) begin
            report_problem(name, "done was still high when the request was raised");
        end
        start = 1'b1;
        @(negedge clk);                             // core has left idle
        while (!done) begin
            if (busy) begin
                img_we   = 1'b1;                    // must not reach orig memory
                img_addr = row_addr_t'(n % img_h);
                img_din  = '1;
                n++;
            end
            @(negedge clk);
        end
        img_we = 1'b0;
        repeat (hold) begin
            @(negedge clk);
            if (!done) begin
                report_problem(name, "done fell while start was still high");
            end
        end
        start = 1'b0;
        @(negedge clk);
        if (done) begin
            report_problem(name, "done did not fall one cycle after start was released");
        end
    endtask

    task automatic run_test(input int i);
        kp_count_t exp_n;
        int        err_before;
        err_before = errors;
        if (t_kind[i] != kind_keep) begin
            build_image(t_kind[i]);
            load_image();
        end
        filter_on = t_filter[i];
        threshold = t_thr[i];
        run_core(t_name[i], t_hold[i], t_busy[i]);
        if (t_count[i] >= 0) begin
            exp_n = kp_count_t'(t_count[i]);
        end else begin
            exp_n = expected_count(frame, t_filter[i], t_thr[i]);
        end
        check_count(t_name[i], exp_n, kp_count);
        for (int k = 0; k < int'(exp_n); k++) begin
            kp_addr = kp_addr_t'(k);                // combinational readback
            @(negedge clk);
            check_entry(t_name[i], k, expected_entry(frame, t_filter[i], t_thr[i], k),
                        kp_dout);
        end
        $display("test %0d %s: %0d keypoints, %s", i, t_name[i], exp_n,
                 (errors == err_before) ? "ok" : "mismatch");
    endtask

    initial begin
        rst_n     = 1'b0;
        start     = 1'b0;
        filter_on = 1'b0;
        threshold = '0;
        img_we    = 1'b0;
        img_addr  = '0;
        img_din   = '0;
        kp_addr   = '0;
        frame     = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_count("reset", '0, kp_count);
        if (done) begin
            report_problem("reset", "done was high after reset");
        end
        for (int i = 0; i < num_tests; i++) begin
            run_test(i);
        end
        $display("summary: %0d tests, %0d checks, %0d errors", num_tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+test
rtl/feature_pkg.sv
rtl/frame_mem.sv
rtl/row_window.sv
rtl/gaussian_blur.sv
rtl/keypoint_detect.sv
rtl/feature_core.sv
test/tb_feature_core.sv
